//--- common/rv_pkg.sv
package rv_pkg;

    localparam int XLEN   = 64;
    localparam int INST_W = 32;
    localparam int REG_AW = 5;

    // major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_RW     = 7'b0111011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    localparam logic [INST_W-1:0] INST_EBREAK = 32'h0010_0073;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // also addi, addw
    localparam logic [2:0] F3_SLTIU   = 3'b011;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SD      = 3'b011;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_JALR    = 3'b000;

    // funct7 values
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'd0,
        ALU_SUB  = 2'd1,
        ALU_SLTU = 2'd2,
        ALU_AND  = 2'd3
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_sel_e;

    typedef enum logic [1:0] {
        SRC_REG     = 2'd0,  // rs1, rs2
        SRC_IMM     = 2'd1,  // rs1, imm
        SRC_IMM_PC  = 2'd2,  // pc, imm
        SRC_FOUR_PC = 2'd3   // pc, 4
    } src_sel_e;

    typedef enum logic [1:0] {
        EXT_NONE   = 2'd0,
        EXT_WORD   = 2'd1,  // sext of alu low word
        EXT_LOAD_W = 2'd2   // sext of loaded word
    } ext_sel_e;

endpackage

//--- decode/ctrl.sv
`timescale 1ns/1ps

module ctrl (
    input  logic [rv_pkg::INST_W-1:0] inst,
    output logic [rv_pkg::REG_AW-1:0] rs1_addr,
    output logic [rv_pkg::REG_AW-1:0] rs2_addr,
    output logic [rv_pkg::REG_AW-1:0] rd_addr,
    output logic                      reg_wen,
    output rv_pkg::alu_op_e           alu_op,
    output rv_pkg::imm_sel_e          imm_sel,
    output rv_pkg::src_sel_e          src_sel,
    output rv_pkg::ext_sel_e          ext_sel,
    output logic                      branch,
    output logic                      jump,
    output logic                      jalr,
    output logic                      load,
    output logic                      store,
    output logic                      ebreak,
    output logic                      unknown
);
    import rv_pkg::*;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        rs1_addr = '0;
        rs2_addr = '0;
        rd_addr  = '0;
        reg_wen  = 1'b0;
        alu_op   = ALU_ADD;
        imm_sel  = IMM_I;
        src_sel  = SRC_REG;
        ext_sel  = EXT_NONE;
        branch   = 1'b0;
        jump     = 1'b0;
        jalr     = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        ebreak   = 1'b0;
        unknown  = 1'b0;
        case (opcode)
            OP_R: begin
                if (funct3 == F3_ADD_SUB && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
                    reg_wen  = 1'b1;
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                    rd_addr  = rd;
                    alu_op   = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                end else begin
                    unknown = 1'b1;
                end
            end
            OP_I: begin
                case (funct3)
                    F3_ADD_SUB, F3_SLTIU: begin  // addi, sltiu
                        reg_wen  = 1'b1;
                        rs1_addr = rs1;
                        rd_addr  = rd;
                        src_sel  = SRC_IMM;
                        alu_op   = (funct3 == F3_SLTIU) ? ALU_SLTU : ALU_ADD;
                    end
                    default: unknown = 1'b1;
                endcase
            end
            OP_RW: begin
                if (funct3 == F3_ADD_SUB && funct7 == F7_ADD) begin  // addw
                    reg_wen  = 1'b1;
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                    rd_addr  = rd;
                    ext_sel  = EXT_WORD;
                end else begin
                    unknown = 1'b1;
                end
            end
            OP_LOAD: begin
                case (funct3)
                    F3_LW: begin
                        reg_wen  = 1'b1;
                        load     = 1'b1;
                        rs1_addr = rs1;
                        rd_addr  = rd;
                        src_sel  = SRC_IMM;
                        ext_sel  = EXT_LOAD_W;
                    end
                    default: unknown = 1'b1;
                endcase
            end
            OP_STORE: begin
                case (funct3)
                    F3_SD: begin
                        store    = 1'b1;  // no rd write
                        rs1_addr = rs1;
                        rs2_addr = rs2;
                        imm_sel  = IMM_S;
                        src_sel  = SRC_IMM;
                    end
                    default: unknown = 1'b1;
                endcase
            end
            OP_BRANCH: begin
                case (funct3)
                    F3_BNE: begin
                        branch   = 1'b1;
                        rs1_addr = rs1;
                        rs2_addr = rs2;
                        imm_sel  = IMM_B;
                        alu_op   = ALU_SUB;  // zero flag compares
                    end
                    default: unknown = 1'b1;
                endcase
            end
            OP_JAL: begin
                jump    = 1'b1;
                reg_wen = 1'b1;
                rd_addr = rd;
                imm_sel = IMM_J;
                src_sel = SRC_FOUR_PC;
            end
            OP_JALR: begin
                case (funct3)
                    F3_JALR: begin
                        jump     = 1'b1;
                        jalr     = 1'b1;
                        reg_wen  = 1'b1;
                        rs1_addr = rs1;
                        rd_addr  = rd;
                        src_sel  = SRC_IMM;  // target = rs1 + imm
                    end
                    default: unknown = 1'b1;
                endcase
            end
            OP_LUI: begin
                reg_wen = 1'b1;
                rd_addr = rd;
                imm_sel = IMM_U;
                src_sel = SRC_IMM;  // x0 + imm
            end
            OP_AUIPC: begin
                reg_wen = 1'b1;
                rd_addr = rd;
                imm_sel = IMM_U;
                src_sel = SRC_IMM_PC;
            end
            default: begin
                if (inst == INST_EBREAK) begin
                    ebreak = 1'b1;
                end else begin
                    unknown = 1'b1;
                end
            end
        endcase
    end

endmodule

//--- decode/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [rv_pkg::INST_W-1:0] inst,
    input  rv_pkg::imm_sel_e          imm_sel,
    output logic [rv_pkg::XLEN-1:0]   imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_sel)
            IMM_I: begin
                imm = {{(XLEN-12){sign}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{(XLEN-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{(XLEN-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21],
                       1'b0};
            end
            IMM_U: begin
                imm = {{(XLEN-32){sign}}, inst[31:12], 12'b0};  // sext from bit 31
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::XLEN-1:0] op_a,
    input  logic [rv_pkg::XLEN-1:0] op_b,
    input  rv_pkg::alu_op_e         alu_op,
    input  rv_pkg::ext_sel_e        ext_sel,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    zero
);
    import rv_pkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] raw;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                raw = sum;
            end
            ALU_SUB: begin
                raw = diff;
            end
            ALU_SLTU: begin
                raw = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            end
            ALU_AND: begin
                raw = op_a & op_b;
            end
            default: begin
                raw = sum;
            end
        endcase
    end

    // word ops keep low 32 bits, sign extended
    assign result = (ext_sel == EXT_WORD) ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

    assign zero = (diff == '0);  // full width, before extension

endmodule

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [rv_pkg::REG_AW-1:0] rs1_addr,
    input  logic [rv_pkg::REG_AW-1:0] rs2_addr,
    input  logic                      wen,
    input  logic [rv_pkg::REG_AW-1:0] rd_addr,
    input  logic [rv_pkg::XLEN-1:0]   rd_data,
    output logic [rv_pkg::XLEN-1:0]   rs1_data,
    output logic [rv_pkg::XLEN-1:0]   rs2_data
);
    import rv_pkg::*;

    localparam int NUM_REGS = 1 << REG_AW;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != '0) begin  // x0 writes dropped
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- source/pc_reg.sv
`timescale 1ns/1ps

module pc_reg #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    branch_taken,
    input  logic                    jump,
    input  logic                    jalr,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic                    ebreak,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    running,
    output logic                    halted
);
    import rv_pkg::*;

    logic [XLEN-1:0] next_pc;

    always_comb begin
        if (ebreak) begin
            next_pc = pc;  // park on the ebreak
        end else if (jalr) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        end else if (jump || branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= RESET_PC;
            running <= 1'b0;
            halted  <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running && !halted) begin
                pc <= next_pc;
                if (ebreak) begin
                    halted <= 1'b1;  // sticky until reset
                end
            end
        end
    end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic [rv_pkg::XLEN-1:0]   inst_addr,
    input  logic [rv_pkg::INST_W-1:0] inst,
    output logic [rv_pkg::XLEN-1:0]   mem_addr,
    input  logic [rv_pkg::XLEN-1:0]   mem_rdata,
    output logic                      mem_wen,
    output logic [rv_pkg::XLEN-1:0]   mem_wdata,
    output logic [7:0]                mem_wmask,
    output logic                      halted,
    output logic                      illegal,
    output logic                      commit_valid,
    output logic [rv_pkg::XLEN-1:0]   commit_pc,
    output logic                      commit_rd_wen,
    output logic [rv_pkg::REG_AW-1:0] commit_rd,
    output logic [rv_pkg::XLEN-1:0]   commit_rd_data
);
    import rv_pkg::*;

    logic [XLEN-1:0]   pc;
    logic              running;
    logic              active;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd_addr;
    logic              reg_wen;
    alu_op_e           alu_op;
    imm_sel_e          imm_sel;
    src_sel_e          src_sel;
    ext_sel_e          ext_sel;
    logic              branch;
    logic              jump;
    logic              jalr;
    logic              load;
    logic              store;
    logic              ebreak;
    logic              unknown;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   alu_result;
    logic              zero;
    logic              branch_taken;
    logic [31:0]       load_word;
    logic [XLEN-1:0]   load_data;
    logic [XLEN-1:0]   wb_data;
    logic              rf_wen;

    ctrl u_ctrl (
        .inst, .rs1_addr, .rs2_addr, .rd_addr, .reg_wen, .alu_op, .imm_sel, .src_sel,
        .ext_sel, .branch, .jump, .jalr, .load, .store, .ebreak, .unknown
    );

    imm_gen u_imm_gen (.inst, .imm_sel, .imm);

    regfile u_regfile (
        .clk, .arst_n, .rs1_addr, .rs2_addr, .wen(rf_wen), .rd_addr, .rd_data(wb_data),
        .rs1_data, .rs2_data
    );

    always_comb begin
        case (src_sel)
            SRC_IMM:     begin op_a = rs1_data; op_b = imm; end
            SRC_IMM_PC:  begin op_a = pc;       op_b = imm; end
            SRC_FOUR_PC: begin op_a = pc;       op_b = XLEN'(4); end
            default:     begin op_a = rs1_data; op_b = rs2_data; end
        endcase
    end

    alu u_alu (.op_a, .op_b, .alu_op, .ext_sel, .result(alu_result), .zero);

    assign branch_taken = branch & ~zero;  // bne

    pc_reg #(.RESET_PC(RESET_PC)) u_pc_reg (
        .clk, .arst_n, .branch_taken, .jump, .jalr, .imm, .alu_result, .ebreak,
        .pc, .running, .halted
    );

    assign active = running & ~halted;

    // word lane picked by address bit 2
    assign load_word = mem_addr[2] ? mem_rdata[63:32] : mem_rdata[31:0];
    assign load_data = (ext_sel == EXT_LOAD_W) ? {{(XLEN-32){load_word[31]}}, load_word}
                                               : mem_rdata;

    always_comb begin
        if (jump) begin
            wb_data = pc + XLEN'(4);  // link address
        end else if (load) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_result;
        end
    end

    assign rf_wen    = reg_wen & active;
    assign inst_addr = pc;
    assign mem_addr  = alu_result;
    assign mem_wdata = rs2_data;
    assign mem_wmask = store ? 8'hFF : 8'h00;
    assign mem_wen   = store & active;
    assign illegal   = unknown & active;

    assign commit_valid   = active;
    assign commit_pc      = pc;
    assign commit_rd_wen  = rf_wen & (rd_addr != '0);  // x0 never reported
    assign commit_rd      = rd_addr;
    assign commit_rd_data = wb_data;

endmodule

//--- tb/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic                      clk,
    input logic                      arst_n,
    input logic [rv_pkg::XLEN-1:0]   inst_addr,
    input logic                      halted,
    input logic                      illegal,
    input logic                      mem_wen,
    input logic                      commit_rd_wen,
    input logic [rv_pkg::REG_AW-1:0] commit_rd
);
    int unsigned fail_count = 0;  // read by the testbench at the end

    illegal_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> !mem_wen && !commit_rd_wen)
    else begin
        fail_count++;
        $error("illegal instruction wrote state");
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
        fail_count++;
        $error("halted dropped without reset");
    end

    halt_pc_stable: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> $stable(inst_addr))
    else begin
        fail_count++;
        $error("inst_addr moved while halted");
    end

    no_x0_commit: assert property (@(posedge clk) disable iff (!arst_n)
        commit_rd_wen |-> commit_rd != '0)
    else begin
        fail_count++;
        $error("register write reported for x0");
    end

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk(clk), .arst_n(arst_n), .inst_addr(inst_addr), .halted(halted), .illegal(illegal),
    .mem_wen(mem_wen), .commit_rd_wen(commit_rd_wen), .commit_rd(commit_rd)
);

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

    typedef struct packed {
        logic [7:0]        pc_off;  // offset from RESET_PC
        logic [31:0]       word;
        logic              rd_wen;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rd_data;
        logic              store;
        logic [XLEN-1:0]   st_addr;
        logic [XLEN-1:0]   st_data;
        logic              ill;
    } trace_row_t;

    logic                clk;
    logic                arst_n;
    logic [XLEN-1:0]     inst_addr;
    logic [INST_W-1:0]   inst;
    logic [XLEN-1:0]     mem_addr;
    logic [XLEN-1:0]     mem_rdata;
    logic                mem_wen;
    logic [XLEN-1:0]     mem_wdata;
    logic [7:0]          mem_wmask;
    logic                halted;
    logic                illegal;
    logic                commit_valid;
    logic [XLEN-1:0]     commit_pc;
    logic                commit_rd_wen;
    logic [REG_AW-1:0]   commit_rd;
    logic [XLEN-1:0]     commit_rd_data;
    logic [INST_W-1:0]   imem [64];
    logic [XLEN-1:0]     dmem [32];
    logic [XLEN-1:0]     inst_off;
    trace_row_t          rows [$];
    int                  errors = 0;
    int                  checks = 0;
    int                  cycle_count = 0;
    int                  timeout_limit = 1000;

    rv_core #(.RESET_PC(RESET_PC)) u_dut (.*);

    always #50 clk = ~clk;

    assign inst_off  = inst_addr - RESET_PC;
    assign inst      = imem[inst_off[7:2]];
    assign mem_rdata = dmem[mem_addr[7:3]];  // combinational read

    always @(posedge clk or negedge arst_n) begin
        logic [XLEN-1:0] merged;
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                dmem[i] <= {32'(i) ^ 32'hda7a_0000, ~32'(i)};
            end
        end else if (mem_wen) begin
            merged = dmem[mem_addr[7:3]];
            for (int b = 0; b < 8; b++) begin
                if (mem_wmask[b]) begin
                    merged[8*b +: 8] = mem_wdata[8*b +: 8];
                end
            end
            dmem[mem_addr[7:3]] <= merged;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: program did not finish within %0d cycles", timeout_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic add_row(input logic [7:0] pc_off, input logic [31:0] word,
                           input logic rd_wen, input logic [4:0] rd, input logic [63:0] rd_data,
                           input logic store, input logic [63:0] st_addr,
                           input logic [63:0] st_data, input logic ill);
        rows.push_back({pc_off, word, rd_wen, rd, rd_data, store, st_addr, st_data, ill});
    endtask

    task automatic build_table();
        add_row(8'h00, 32'h123450b7, 1'b1, 5'd1, 64'h12345000, 1'b0, '0, '0, 1'b0);  // lui
        add_row(8'h04, 32'h67808113, 1'b1, 5'd2, 64'h12345678, 1'b0, '0, '0, 1'b0);
        add_row(8'h08, 32'hfff00193, 1'b1, 5'd3, '1, 1'b0, '0, '0, 1'b0);  // addi -1
        add_row(8'h0c, 32'h00310233, 1'b1, 5'd4, 64'h12345677, 1'b0, '0, '0, 1'b0);
        add_row(8'h10, 32'h401102b3, 1'b1, 5'd5, 64'h678, 1'b0, '0, '0, 1'b0);  // sub
        add_row(8'h14, 32'h6792b313, 1'b1, 5'd6, 64'h1, 1'b0, '0, '0, 1'b0);  // sltiu true
        add_row(8'h18, 32'h6782b393, 1'b1, 5'd7, 64'h0, 1'b0, '0, '0, 1'b0);  // sltiu false
        add_row(8'h1c, 32'h7ffff437, 1'b1, 5'd8, 64'h7ffff000, 1'b0, '0, '0, 1'b0);
        add_row(8'h20, 32'h008404bb, 1'b1, 5'd9, 64'hffff_ffff_ffff_e000, 1'b0, '0, '0, 1'b0);
        add_row(8'h24, 32'h00510013, 1'b0, 5'd0, '0, 1'b0, '0, '0, 1'b0);  // addi x0
        add_row(8'h28, 32'h00200533, 1'b1, 5'd10, 64'h12345678, 1'b0, '0, '0, 1'b0);
        add_row(8'h2c, 32'h008405b3, 1'b1, 5'd11, 64'hffffe000, 1'b0, '0, '0, 1'b0);
        add_row(8'h30, 32'h00b03c23, 1'b0, 5'd0, '0, 1'b1, 64'h18, 64'hffffe000, 1'b0);  // sd
        add_row(8'h34, 32'h01802603, 1'b1, 5'd12, 64'hffff_ffff_ffff_e000, 1'b0, '0, '0, 1'b0);
        add_row(8'h38, 32'h01c02683, 1'b1, 5'd13, 64'h0, 1'b0, '0, '0, 1'b0);  // upper word
        add_row(8'h3c, 32'h00221463, 1'b0, 5'd0, '0, 1'b0, '0, '0, 1'b0);  // bne taken
        add_row(8'h44, 32'h00251463, 1'b0, 5'd0, '0, 1'b0, '0, '0, 1'b0);  // bne not taken
        add_row(8'h48, 32'h00001717, 1'b1, 5'd14, 64'h80001048, 1'b0, '0, '0, 1'b0);
        add_row(8'h4c, 32'h00c007ef, 1'b1, 5'd15, 64'h80000050, 1'b0, '0, '0, 1'b0);  // jal
        add_row(8'h58, 32'h01578867, 1'b1, 5'd16, 64'h8000005c, 1'b0, '0, '0, 1'b0);  // jalr
        add_row(8'h64, 32'h003140b3, 1'b0, 5'd0, '0, 1'b0, '0, '0, 1'b1);  // xor, unsupported
        add_row(8'h68, 32'h000088b3, 1'b1, 5'd17, 64'h12345000, 1'b0, '0, '0, 1'b0);
        add_row(8'h6c, INST_EBREAK, 1'b0, 5'd0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_row(input int idx);
        trace_row_t r;
        string      tag;
        r   = rows[idx];
        tag = $sformatf(" (row %0d)", idx);
        check_value({"commit_valid", tag}, 64'(commit_valid), 64'd1);
        check_value({"commit_pc", tag}, commit_pc, RESET_PC + 64'(r.pc_off));
        check_value({"commit_rd_wen", tag}, 64'(commit_rd_wen), 64'(r.rd_wen));
        if (r.rd_wen) begin
            check_value({"commit_rd", tag}, 64'(commit_rd), 64'(r.rd));
            check_value({"commit_rd_data", tag}, commit_rd_data, r.rd_data);
        end
        check_value({"mem_wen", tag}, 64'(mem_wen), 64'(r.store));
        if (r.store) begin
            check_value({"mem_addr", tag}, mem_addr, r.st_addr);
            check_value({"mem_wdata", tag}, mem_wdata, r.st_data);
            check_value({"mem_wmask", tag}, 64'(mem_wmask), 64'hff);
        end
        check_value({"illegal", tag}, 64'(illegal), 64'(r.ill));
    endtask

    initial begin
        logic [XLEN-1:0] halt_pc;
        clk    = 1'b0;
        arst_n = 1'b0;
        build_table();
        timeout_limit = rows.size() * 2 + 20;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'(i) << 7;  // opcode 0, decodes as illegal
        end
        foreach (rows[i]) begin
            imem[rows[i].pc_off[7:2]] = rows[i].word;
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (!commit_valid) begin
            @(negedge clk);
        end
        foreach (rows[i]) begin
            check_row(i);
            @(negedge clk);
        end
        halt_pc = RESET_PC + 64'(rows[rows.size() - 1].pc_off);
        repeat (5) begin
            check_value("halted", 64'(halted), 64'd1);
            check_value("commit_valid", 64'(commit_valid), 64'd0);
            check_value("inst_addr", inst_addr, halt_pc);
            check_value("mem_wen", 64'(mem_wen), 64'd0);
            @(negedge clk);
        end
        if (u_dut.u_assertions.fail_count != 0) begin
            errors++;
            $display("bound assertions failed %0d times", u_dut.u_assertions.fail_count);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim.f
common/rv_pkg.sv
decode/ctrl.sv
decode/imm_gen.sv
source/alu.sv
source/regfile.sv
source/pc_reg.sv
source/rv_core.sv
tb/rv_core_assertions.sv
tb/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -f sim.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/sim_rv_core +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
